// File: Makefile
BIN := obj_dir/Vnco_tb

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

$(BIN): project.f $(wildcard logic/*.sv tests/*.sv include/*.svh)
	verilator --binary --timing -j 0 --top-module nco_tb -f project.f

clean:
	rm -rf obj_dir

// File: include/nco_cfg.svh
/*
 * NCO configuration: bus, period and crossing FIFO sizes
 */
`ifndef NCO_CFG_SVH
`define NCO_CFG_SVH

// period in fixed point with 8 fraction bits
`define NCO_PERIOD_W 24
`define NCO_FRAC_W 8

// csr bus
`define NCO_CSR_ADDR_W 2
`define NCO_CSR_DATA_W 32

// two-entry period FIFO
`define NCO_FIFO_ADDR_W 1

`endif

// File: logic/nco_accumulator.sv
/*
 * NCO fractional accumulator: adds one in_clk cycle per clock and
 * toggles clk_o each time the sum passes the period
 */
`timescale 1ns/1ps
`include "nco_cfg.svh"

module nco_accumulator (
   input  logic   in_clk_i,
   input  logic   in_reset_i,
   nco_cfg_if.snk cfg,
   output logic   clk_o
);

   // one extra bit so the sum never overflows
   localparam int ACC_W = `NCO_PERIOD_W + 1;
   localparam logic [ACC_W-1:0] STEP = ACC_W'(1) << `NCO_FRAC_W;

   nco_core_pkg::nco_acc_state_e state_q;
   nco_core_pkg::nco_period_t    period_q;
   logic [ACC_W-1:0]             acc_q;
   logic [ACC_W-1:0]             sum;
   logic [ACC_W-1:0]             period_ext;
   logic                         wrap;
   logic                         clk_q;

   // no back-pressure toward the oscillator
   assign cfg.period_full = 1'b0;

   assign period_ext = ACC_W'(period_q);
   assign sum        = acc_q + STEP;
   assign wrap       = (sum >= period_ext);

   always_ff @(posedge in_clk_i) begin
      if (in_reset_i) begin
         state_q  <= nco_core_pkg::ACC_IDLE;
         period_q <= '0;
         acc_q    <= '0;
         clk_q    <= 1'b0;
      end else begin
         // new period takes effect from the next cycle
         if (cfg.period_wen) begin
            period_q <= cfg.period;
         end
         if (cfg.soft_reset) begin
            state_q <= nco_core_pkg::ACC_IDLE;
            acc_q   <= '0;
            clk_q   <= 1'b0;
         end else begin
            case (state_q)
               nco_core_pkg::ACC_IDLE: begin
                  if (cfg.enable) begin
                     state_q <= nco_core_pkg::ACC_RUN;
                  end
               end
               nco_core_pkg::ACC_RUN: begin
                  if (!cfg.enable) begin
                     // phase and output are held
                     state_q <= nco_core_pkg::ACC_IDLE;
                  end else begin
                     acc_q <= wrap ? (sum - period_ext) : sum;
                     clk_q <= clk_q ^ wrap;
                  end
               end
               default: state_q <= nco_core_pkg::ACC_IDLE;
            endcase
         end
      end
   end

   assign clk_o = clk_q;

endmodule

// File: logic/nco_cfg_if.sv
/*
 * NCO settings bundle passed between the CSR block, the crossing and the core
 */
`timescale 1ns/1ps

interface nco_cfg_if ();

   logic                      enable;
   logic                      soft_reset;
   nco_core_pkg::nco_period_t period;
   // one-cycle strobe, period is valid with it
   logic                      period_wen;
   logic                      period_full;

   modport src (
      output enable,
      output soft_reset,
      output period,
      output period_wen,
      input  period_full
   );

   modport snk (
      input  enable,
      input  soft_reset,
      input  period,
      input  period_wen,
      output period_full
   );

endinterface

// File: logic/nco_core_pkg.sv
/*
 * NCO core package: oscillator types
 */
`include "nco_cfg.svh"

package nco_core_pkg;

   // half period in in_clk cycles, 8 fraction bits
   typedef logic [`NCO_PERIOD_W-1:0] nco_period_t;

   // accumulator runs only while enabled
   typedef enum logic {
      ACC_IDLE = 1'b0,
      ACC_RUN  = 1'b1
   } nco_acc_state_e;

endpackage

// File: logic/nco_csr_pkg.sv
/*
 * NCO CSR package: register map and bus word types
 */
`include "nco_cfg.svh"

package nco_csr_pkg;

   // register map, unlisted addresses read as zero
   typedef enum logic [`NCO_CSR_ADDR_W-1:0] {
      NCO_CTRL   = `NCO_CSR_ADDR_W'(0),
      NCO_PERIOD = `NCO_CSR_ADDR_W'(1)
   } nco_csr_addr_e;

   typedef logic [`NCO_CSR_DATA_W-1:0] nco_csr_data_t;

   // layout of the CTRL word
   typedef struct packed {
      logic [`NCO_CSR_DATA_W-3:0] rsvd;
      logic                       soft_reset;
      logic                       enable;
   } nco_ctrl_t;

endpackage

// File: logic/nco_csr_regs.sv
/*
 * NCO register block: valid/ready CSR access, CTRL bits and period
 * with a write strobe toward the crossing FIFO
 */
`timescale 1ns/1ps
`include "nco_cfg.svh"

module nco_csr_regs (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       csr_valid_i,
   input  logic                       csr_we_i,
   input  nco_csr_pkg::nco_csr_addr_e csr_addr_i,
   input  nco_csr_pkg::nco_csr_data_t csr_wdata_i,
   output logic                       csr_ready_o,
   output logic                       csr_rvalid_o,
   output nco_csr_pkg::nco_csr_data_t csr_rdata_o,
   nco_cfg_if.src                     cfg
);

   logic                       is_period;
   logic                       xfer;
   logic                       wr_ctrl;
   logic                       wr_period;
   logic                       rd_xfer;
   nco_csr_pkg::nco_ctrl_t     wdata_ctrl;
   nco_csr_pkg::nco_ctrl_t     ctrl_q;
   nco_core_pkg::nco_period_t  period_q;
   logic                       period_wen_q;
   logic                       rvalid_q;
   nco_csr_pkg::nco_csr_data_t rdata_d;
   nco_csr_pkg::nco_csr_data_t rdata_q;

   assign is_period = (csr_addr_i == nco_csr_pkg::NCO_PERIOD);

   // only a period write can stall, and only while the FIFO has no room
   assign csr_ready_o = !(csr_we_i && is_period && cfg.period_full);

   assign xfer       = csr_valid_i && csr_ready_o;
   assign wr_ctrl    = xfer && csr_we_i && (csr_addr_i == nco_csr_pkg::NCO_CTRL);
   assign wr_period  = xfer && csr_we_i && is_period;
   assign rd_xfer    = xfer && !csr_we_i;
   assign wdata_ctrl = csr_wdata_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_q       <= '0;
         period_q     <= '0;
         period_wen_q <= 1'b0;
         rvalid_q     <= 1'b0;
      end else begin
         period_wen_q <= wr_period;
         rvalid_q     <= rd_xfer;
         if (wr_ctrl) begin
            ctrl_q.enable     <= wdata_ctrl.enable;
            ctrl_q.soft_reset <= wdata_ctrl.soft_reset;
         end
         if (wr_period) begin
            period_q <= csr_wdata_i[`NCO_PERIOD_W-1:0];
         end
      end
   end

   // read mux
   always_comb begin
      rdata_d = '0;
      case (csr_addr_i)
         nco_csr_pkg::NCO_CTRL:   rdata_d = ctrl_q;
         nco_csr_pkg::NCO_PERIOD: rdata_d[`NCO_PERIOD_W-1:0] = period_q;
         default:                 rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rd_xfer) begin
         rdata_q <= rdata_d;
      end
   end

   assign csr_rvalid_o = rvalid_q;
   assign csr_rdata_o  = rdata_q;

   assign cfg.enable     = ctrl_q.enable;
   assign cfg.soft_reset = ctrl_q.soft_reset;
   assign cfg.period     = period_q;
   assign cfg.period_wen = period_wen_q;

endmodule

// File: logic/nco_domain_sync.sv
/*
 * NCO domain crossing: control bit synchronizers and a two-entry
 * Gray-pointer FIFO that moves period values into the in_clk domain
 */
`timescale 1ns/1ps
`include "nco_cfg.svh"

module nco_domain_sync (
   input  logic   clk_i,
   input  logic   reset_i,
   input  logic   in_clk_i,
   input  logic   in_reset_i,
   nco_cfg_if.snk cfg_i,
   nco_cfg_if.src cfg_o
);

   localparam int ADDR_W = `NCO_FIFO_ADDR_W;
   localparam int PTR_W  = ADDR_W + 1;
   localparam int DEPTH  = 1 << ADDR_W;
   // full when the two top Gray bits differ and the rest match
   localparam logic [PTR_W-1:0] FULL_MASK = PTR_W'(3) << (PTR_W - 2);

   function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   // bit 0 enable, bit 1 soft reset
   logic [1:0]                ctrl_meta_q;
   logic [1:0]                ctrl_sync_q;

   nco_core_pkg::nco_period_t mem [DEPTH];

   // write side, clk_i
   logic [PTR_W-1:0]          w_bin_q;
   logic [PTR_W-1:0]          w_gray_q;
   logic [PTR_W-1:0]          w_bin_next;
   logic [PTR_W-1:0]          w_gray_next;
   logic [PTR_W-1:0]          r_gray_meta_q;
   logic [PTR_W-1:0]          r_gray_sync_q;
   logic                      w_full;
   logic                      w_en;

   // read side, in_clk_i
   logic [PTR_W-1:0]          r_bin_q;
   logic [PTR_W-1:0]          r_gray_q;
   logic [PTR_W-1:0]          r_bin_next;
   logic [PTR_W-1:0]          w_gray_meta_q;
   logic [PTR_W-1:0]          w_gray_sync_q;
   logic                      r_empty;
   logic                      r_en;
   nco_core_pkg::nco_period_t period_q;
   logic                      period_wen_q;

   // writes are dropped during soft reset, the read side drains the rest
   assign w_full      = (w_gray_q == (r_gray_sync_q ^ FULL_MASK));
   assign w_en        = cfg_i.period_wen && !cfg_i.soft_reset && !w_full;
   assign w_bin_next  = w_bin_q + PTR_W'(w_en);
   assign w_gray_next = bin2gray(w_bin_next);

   // raised one write early so a strobe already in flight still fits
   assign cfg_i.period_full = (w_gray_next == (r_gray_sync_q ^ FULL_MASK));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_bin_q       <= '0;
         w_gray_q      <= '0;
         r_gray_meta_q <= '0;
         r_gray_sync_q <= '0;
      end else begin
         w_bin_q       <= w_bin_next;
         w_gray_q      <= w_gray_next;
         r_gray_meta_q <= r_gray_q;
         r_gray_sync_q <= r_gray_meta_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_en) begin
         mem[w_bin_q[ADDR_W-1:0]] <= cfg_i.period;
      end
   end

   // read whenever something is waiting
   assign r_empty    = (r_gray_q == w_gray_sync_q);
   assign r_en       = !r_empty;
   assign r_bin_next = r_bin_q + PTR_W'(1);

   always_ff @(posedge in_clk_i) begin
      if (in_reset_i) begin
         r_bin_q       <= '0;
         r_gray_q      <= '0;
         w_gray_meta_q <= '0;
         w_gray_sync_q <= '0;
         ctrl_meta_q   <= '0;
         ctrl_sync_q   <= '0;
         period_wen_q  <= 1'b0;
      end else begin
         w_gray_meta_q <= w_gray_q;
         w_gray_sync_q <= w_gray_meta_q;
         ctrl_meta_q   <= {cfg_i.soft_reset, cfg_i.enable};
         ctrl_sync_q   <= ctrl_meta_q;
         period_wen_q  <= r_en;
         if (r_en) begin
            r_bin_q  <= r_bin_next;
            r_gray_q <= bin2gray(r_bin_next);
         end
      end
   end

   always_ff @(posedge in_clk_i) begin
      if (r_en) begin
         period_q <= mem[r_bin_q[ADDR_W-1:0]];
      end
   end

   assign cfg_o.enable     = ctrl_sync_q[0];
   assign cfg_o.soft_reset = ctrl_sync_q[1];
   assign cfg_o.period     = period_q;
   assign cfg_o.period_wen = period_wen_q;

endmodule

// File: logic/nco_top.sv
/*
 * NCO top: CSR block, clock domain crossing and fractional oscillator
 */
`timescale 1ns/1ps
`include "nco_cfg.svh"

module nco_top (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       in_clk_i,
   input  logic                       in_reset_i,
   input  logic                       csr_valid_i,
   output logic                       csr_ready_o,
   input  logic                       csr_we_i,
   input  logic [`NCO_CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [`NCO_CSR_DATA_W-1:0] csr_wdata_i,
   output logic [`NCO_CSR_DATA_W-1:0] csr_rdata_o,
   output logic                       csr_rvalid_o,
   output logic                       clk_o
);

   // settings on the csr side and on the oscillator side
   nco_cfg_if cfg_csr ();
   nco_cfg_if cfg_osc ();

   nco_csr_regs i_csr_regs (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .csr_valid_i (csr_valid_i),
      .csr_we_i    (csr_we_i),
      .csr_addr_i  (nco_csr_pkg::nco_csr_addr_e'(csr_addr_i)),
      .csr_wdata_i (csr_wdata_i),
      .csr_ready_o (csr_ready_o),
      .csr_rvalid_o(csr_rvalid_o),
      .csr_rdata_o (csr_rdata_o),
      .cfg         (cfg_csr.src)
   );

   nco_domain_sync i_domain_sync (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .in_clk_i  (in_clk_i),
      .in_reset_i(in_reset_i),
      .cfg_i     (cfg_csr.snk),
      .cfg_o     (cfg_osc.src)
   );

   nco_accumulator i_accumulator (
      .in_clk_i  (in_clk_i),
      .in_reset_i(in_reset_i),
      .cfg       (cfg_osc.snk),
      .clk_o     (clk_o)
   );

endmodule

// File: project.f
+incdir+include
logic/nco_csr_pkg.sv
logic/nco_core_pkg.sv
logic/nco_cfg_if.sv
logic/nco_csr_regs.sv
logic/nco_domain_sync.sv
logic/nco_accumulator.sv
logic/nco_top.sv
tests/nco_checker.sv
tests/nco_tb.sv

// File: tests/nco_checker.sv
/*
 * NCO checker: times clk_o half periods against the expected period
 * and compares CSR reads with a shadow of the registers
 */
`timescale 1ns/1ps
`include "nco_cfg.svh"

module nco_checker (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       in_clk_i,
   input  logic                       in_reset_i,
   input  logic                       csr_valid_i,
   input  logic                       csr_ready_i,
   input  logic                       csr_we_i,
   input  logic [`NCO_CSR_ADDR_W-1:0] csr_addr_i,
   input  logic [`NCO_CSR_DATA_W-1:0] csr_wdata_i,
   input  logic [`NCO_CSR_DATA_W-1:0] csr_rdata_i,
   input  logic                       csr_rvalid_i,
   input  logic                       nco_clk_i,
   input  logic [127:0]               test_name_i,
   input  logic [31:0]                period_i,
   input  logic                       measure_i,
   input  logic                       hold_i,
   input  logic                       idle_i,
   output logic                       done_o,
   output int                         csr_errors_o,
   output int                         osc_errors_o
);

   localparam int TOGGLES = 40;
   localparam int WAIT_EDGE = 0;
   localparam int TIMING = 1;
   localparam int FINISHED = 2;
   localparam logic [`NCO_CSR_ADDR_W-1:0] CTRL_ADDR   = `NCO_CSR_ADDR_W'(0);
   localparam logic [`NCO_CSR_ADDR_W-1:0] PERIOD_ADDR = `NCO_CSR_ADDR_W'(1);

   logic [1:0]                 ctrl_shadow;
   logic [`NCO_PERIOD_W-1:0]   period_shadow;
   logic                       read_pending;
   logic [`NCO_CSR_ADDR_W-1:0] read_addr;
   logic [`NCO_CSR_DATA_W-1:0] read_expected;
   int                         csr_fails;
   logic                       last_clk;
   logic                       toggled;
   int                         phase;
   int                         cycles;
   int                         count;
   int                         total;
   int                         osc_fails;

   // register map: CTRL keeps bits 1:0, PERIOD keeps the low period bits
   function automatic logic [`NCO_CSR_DATA_W-1:0] expected_read(
      input logic [`NCO_CSR_ADDR_W-1:0] addr);
      logic [`NCO_CSR_DATA_W-1:0] value;
      value = '0;
      if (addr == CTRL_ADDR) begin
         value[1:0] = ctrl_shadow;
      end else if (addr == PERIOD_ADDR) begin
         value[`NCO_PERIOD_W-1:0] = period_shadow;
      end
      return value;
   endfunction

   // half period is floor(P/256), or one more when P has a fraction
   function automatic int half_min(input logic [31:0] p);
      return int'(p >> `NCO_FRAC_W);
   endfunction

   function automatic int half_max(input logic [31:0] p);
      return (p[`NCO_FRAC_W-1:0] == '0) ? half_min(p) : half_min(p) + 1;
   endfunction

   function automatic int expected_total(input logic [31:0] p);
      return (TOGGLES * int'(p) + 128) / 256;
   endfunction

   // total over all toggles within one cycle of N*P/256
   function automatic logic total_in_range(input int sum, input logic [31:0] p);
      int diff;
      diff = sum * 256 - TOGGLES * int'(p);
      return (diff >= -256) && (diff <= 256);
   endfunction

   always @(posedge clk_i) begin
      csr_fails = 0;
      if (reset_i) begin
         ctrl_shadow   <= '0;
         period_shadow <= '0;
         read_pending  <= 1'b0;
         csr_errors_o  <= 0;
      end else begin
         if (read_pending && !csr_rvalid_i) begin
            $display("error in %0s: no csr_rvalid_o one cycle after a read", test_name_i);
            csr_fails = csr_fails + 1;
         end else if (read_pending && csr_rdata_i != read_expected) begin
            $display("mismatch %0s: read of address %0d expected %h, got %h",
                     test_name_i, read_addr, read_expected, csr_rdata_i);
            csr_fails = csr_fails + 1;
         end else if (!read_pending && csr_rvalid_i) begin
            $display("error in %0s: csr_rvalid_o high without a read", test_name_i);
            csr_fails = csr_fails + 1;
         end
         if (idle_i && nco_clk_i != 1'b0) begin
            $display("mismatch %0s: clk_o expected 0, got %b", test_name_i, nco_clk_i);
            csr_fails = csr_fails + 1;
         end
         if (idle_i && !csr_ready_i) begin
            $display("mismatch %0s: csr_ready_o expected 1, got 0", test_name_i);
            csr_fails = csr_fails + 1;
         end
         read_pending  <= csr_valid_i && csr_ready_i && !csr_we_i;
         read_addr     <= csr_addr_i;
         read_expected <= expected_read(csr_addr_i);
         if (csr_valid_i && csr_ready_i && csr_we_i && csr_addr_i == CTRL_ADDR) begin
            ctrl_shadow <= csr_wdata_i[1:0];
         end
         if (csr_valid_i && csr_ready_i && csr_we_i && csr_addr_i == PERIOD_ADDR) begin
            period_shadow <= csr_wdata_i[`NCO_PERIOD_W-1:0];
         end
         csr_errors_o <= csr_errors_o + csr_fails;
      end
   end

   // clk_o half periods counted in in_clk cycles
   always @(posedge in_clk_i) begin
      osc_fails = 0;
      toggled = (nco_clk_i != last_clk);
      last_clk = nco_clk_i;
      if (in_reset_i) begin
         phase = WAIT_EDGE;
         done_o <= 1'b0;
         osc_errors_o <= 0;
      end else begin
         if (hold_i && toggled) begin
            $display("error in %0s: clk_o toggled while enable was cleared", test_name_i);
            osc_fails = osc_fails + 1;
         end
         if (!measure_i) begin
            phase = WAIT_EDGE;
            done_o <= 1'b0;
         end else if (phase == WAIT_EDGE && toggled) begin
            phase = TIMING;
            cycles = 0;
            count = 0;
            total = 0;
         end else if (phase == TIMING) begin
            cycles = cycles + 1;
            if (toggled) begin
               if (cycles < half_min(period_i) || cycles > half_max(period_i)) begin
                  $display("mismatch %0s: half period expected %0d to %0d cycles, got %0d",
                           test_name_i, half_min(period_i), half_max(period_i), cycles);
                  osc_fails = osc_fails + 1;
               end
               total = total + cycles;
               count = count + 1;
               cycles = 0;
            end
            if (count == TOGGLES) begin
               if (!total_in_range(total, period_i)) begin
                  $display("mismatch %0s: %0d half periods expected %0d cycles, got %0d",
                           test_name_i, TOGGLES, expected_total(period_i), total);
                  osc_fails = osc_fails + 1;
               end
               phase = FINISHED;
               done_o <= 1'b1;
            end
         end
         osc_errors_o <= osc_errors_o + osc_fails;
      end
   end

endmodule

// File: tests/nco_tb.sv
/*
 * NCO testbench: two clocks, CSR traffic over the valid/ready bus,
 * period sweeps, control bit and back-pressure tests
 */
`timescale 1ns/1ps
`include "nco_cfg.svh"

module nco_tb;

   // 6 periods x 40 toggles x at most 40 in_clk cycles, with margin
   localparam int TIMEOUT_CYCLES = 20000;
   localparam logic [`NCO_CSR_ADDR_W-1:0] CTRL_ADDR   = `NCO_CSR_ADDR_W'(0);
   localparam logic [`NCO_CSR_ADDR_W-1:0] PERIOD_ADDR = `NCO_CSR_ADDR_W'(1);

   logic                       clk_i;
   logic                       reset_i;
   logic                       in_clk_i;
   logic                       in_reset_i;
   logic                       csr_valid_i;
   logic                       csr_ready_o;
   logic                       csr_we_i;
   logic [`NCO_CSR_ADDR_W-1:0] csr_addr_i;
   logic [`NCO_CSR_DATA_W-1:0] csr_wdata_i;
   logic [`NCO_CSR_DATA_W-1:0] csr_rdata_o;
   logic                       csr_rvalid_o;
   logic                       clk_o;
   logic [127:0]               test_name;
   logic [31:0]                period_exp;
   logic [31:0]                rand_period;
   logic                       measure;
   logic                       hold;
   logic                       idle;
   logic                       meas_done;
   int                         csr_errors;
   int                         osc_errors;
   int                         cycle_count = 0;
   int unsigned                seed_value;

   nco_top i_dut (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_clk_i    (in_clk_i),
      .in_reset_i  (in_reset_i),
      .csr_valid_i (csr_valid_i),
      .csr_ready_o (csr_ready_o),
      .csr_we_i    (csr_we_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_rdata_o (csr_rdata_o),
      .csr_rvalid_o(csr_rvalid_o),
      .clk_o       (clk_o)
   );

   nco_checker i_checker (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_clk_i    (in_clk_i),
      .in_reset_i  (in_reset_i),
      .csr_valid_i (csr_valid_i),
      .csr_ready_i (csr_ready_o),
      .csr_we_i    (csr_we_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_rdata_i (csr_rdata_o),
      .csr_rvalid_i(csr_rvalid_o),
      .nco_clk_i   (clk_o),
      .test_name_i (test_name),
      .period_i    (period_exp),
      .measure_i   (measure),
      .hold_i      (hold),
      .idle_i      (idle),
      .done_o      (meas_done),
      .csr_errors_o(csr_errors),
      .osc_errors_o(osc_errors)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   initial begin
      in_clk_i = 1'b0;
      forever #7 in_clk_i = ~in_clk_i;
   end

   // inputs change 2 ns after the clk_i edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_i);
      #2;
   endtask

   // holds the request until the cycle where ready is seen high
   task automatic csr_access(input logic we, input logic [`NCO_CSR_ADDR_W-1:0] addr,
                             input logic [`NCO_CSR_DATA_W-1:0] data);
      csr_valid_i = 1'b1;
      csr_we_i = we;
      csr_addr_i = addr;
      csr_wdata_i = data;
      @(posedge clk_i);
      while (!csr_ready_o) @(posedge clk_i);
      #2;
      csr_valid_i = 1'b0;
      csr_we_i = 1'b0;
   endtask

   task automatic csr_write(input logic [`NCO_CSR_ADDR_W-1:0] addr,
                            input logic [`NCO_CSR_DATA_W-1:0] data);
      csr_access(1'b1, addr, data);
   endtask

   task automatic csr_read(input logic [`NCO_CSR_ADDR_W-1:0] addr);
      csr_access(1'b0, addr, '0);
   endtask

   // first 4 toggles may still follow the previous period
   task automatic check_period(input logic [127:0] name, input logic [31:0] p);
      test_name = name;
      repeat (4) @(clk_o);
      wait_cycles(1);
      period_exp = p;
      measure = 1'b1;
      while (!meas_done) wait_cycles(1);
      measure = 1'b0;
   endtask

   // 6.0 to 12.0 keeps the step between periods at most a factor of two
   function automatic logic [31:0] pick_fractional_period();
      logic [31:0] p;
      p = $urandom_range(12 * 256 - 1, 6 * 256);
      if (p[7:0] == 8'h00) begin
         p = p + 32'd1;
      end
      return p;
   endfunction

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d clk_i cycles", TIMEOUT_CYCLES);
         $display("error counts: csr %0d, oscillator %0d", csr_errors, osc_errors);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      seed_value = $urandom(32'hdec1);
      reset_i = 1'b1;
      in_reset_i = 1'b1;
      csr_valid_i = 1'b0;
      csr_we_i = 1'b0;
      csr_addr_i = '0;
      csr_wdata_i = '0;
      test_name = "reset";
      period_exp = '0;
      rand_period = '0;
      measure = 1'b0;
      hold = 1'b0;
      idle = 1'b0;
      fork
         begin
            repeat (5) @(posedge clk_i);
            #2 reset_i = 1'b0;
         end
         begin
            repeat (5) @(posedge in_clk_i);
            #2 in_reset_i = 1'b0;
         end
      join
      wait_cycles(1);

      test_name = "after_reset";
      idle = 1'b1;
      wait_cycles(20);
      idle = 1'b0;

      test_name = "csr_readback";
      csr_write(CTRL_ADDR, 32'hffff_fffc);
      csr_read(CTRL_ADDR);
      csr_write(CTRL_ADDR, 32'h0000_0003);
      csr_read(CTRL_ADDR);
      csr_write(CTRL_ADDR, 32'h0000_0000);
      csr_write(PERIOD_ADDR, 32'hab00_0400);
      csr_read(PERIOD_ADDR);
      csr_read(CTRL_ADDR);
      csr_write(`NCO_CSR_ADDR_W'(2), 32'h1234_5678);
      csr_read(`NCO_CSR_ADDR_W'(2));
      csr_read(`NCO_CSR_ADDR_W'(3));

      // integer periods 4.0 and 10.0
      csr_write(CTRL_ADDR, 32'h1);
      check_period("period_4_0", 32'd1024);
      csr_write(PERIOD_ADDR, 32'd2560);
      check_period("period_10_0", 32'd2560);

      for (int k = 0; k < 2; k++) begin
         rand_period = pick_fractional_period();
         csr_write(PERIOD_ADDR, rand_period);
         csr_read(PERIOD_ADDR);
         check_period("period_random", rand_period);
      end

      // stop right after a rising clk_o so the held level is high
      test_name = "disable";
      @(posedge clk_o);
      wait_cycles(1);
      csr_write(CTRL_ADDR, 32'h0);
      wait_cycles(5);
      hold = 1'b1;
      wait_cycles(50);
      hold = 1'b0;
      test_name = "soft_reset";
      csr_write(CTRL_ADDR, 32'h2);
      wait_cycles(5);
      idle = 1'b1;
      wait_cycles(10);
      idle = 1'b0;
      csr_read(CTRL_ADDR);
      csr_write(CTRL_ADDR, 32'h1);
      check_period("restart", rand_period);

      // the third write may stall while the FIFO is full
      test_name = "back_pressure";
      csr_write(PERIOD_ADDR, pick_fractional_period());
      csr_write(PERIOD_ADDR, pick_fractional_period());
      rand_period = pick_fractional_period();
      csr_write(PERIOD_ADDR, rand_period);
      csr_read(PERIOD_ADDR);
      check_period("back_pressure", rand_period);

      wait_cycles(5);
      $display("error counts: csr %0d, oscillator %0d", csr_errors, osc_errors);
      if (csr_errors == 0 && osc_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
